// ==== vlog.f ====
design/render_pkg.sv
design/scene_regs.sv
design/tank_sprite.sv
design/bullet_hit.sv
design/win_banner.sv
design/pixel_compose.sv
design/tank_renderer.sv
verif/tb_tank_renderer_assert.sv
verif/tb_tank_renderer.sv

// ==== Makefile ====
# Verilator build and run of the tank renderer testbench
VERILATOR ?= verilator
TOP       ?= tb_tank_renderer
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "no pass message in log"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_tank_renderer.sv ====
// directed testbench for tank_renderer; drives host writes and pixels, checks rgb against the drawing rules
`timescale 1ns/100ps

module tb_tank_renderer;
    import render_pkg::*;

    // loose bound on the whole directed run
    localparam int MAX_CYCLES = 6000;

    logic        pclk, in_reset_hint, wr_req, wr_ack, in_display, map_wall;
    reg_addr_t   wr_addr;
    reg_data_t   wr_data;
    coord_t      pixel_x, map_rd_x, map_rd_y;
    row_t        pixel_y;
    rgb_t        rgb;
    int          cycles = 0;
    logic [31:0] rng = 32'd18580;
    int          bx [4];
    int          by [4];

    tank_renderer #(.BULLET_NUM(8)) i_dut (.*);

    // wall map model, one column
    assign map_wall = (map_rd_x == 8'd100);

    initial begin
        pclk = 1'b0;
        forever #20 pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // expected body shape inside the 3x4 box
    function automatic logic sprite_on(input int dir, input int c, input int r);
        case (dir)
            0: return !(r == 0 && c != 1);
            1: return !(r == 3 && c != 1);
            2: return (c == 0) ? (r == 1) : (r < 3);
            default: return (c == 2) ? (r == 1) : (r < 3);
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("** FAIL **");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // full four-phase write
    task automatic host_write(input int addr, input reg_data_t data);
        @(negedge pclk);
        wr_addr = reg_addr_t'(addr);
        wr_data = data;
        wr_req  = 1'b1;
        @(negedge pclk);
        while (!wr_ack) begin
            @(negedge pclk);
        end
        wr_req = 1'b0;
        @(negedge pclk);
        while (wr_ack) begin
            @(negedge pclk);
        end
    endtask

    task automatic probe(input int x, input int y, input rgb_t exp);
        @(negedge pclk);
        pixel_x = coord_t'(x);
        pixel_y = row_t'(y);
        @(negedge pclk);
        expect_eq("map_rd_x", map_rd_x, coord_t'(x));
        // map row is the play-field row
        if (y >= STATUS_HEIGHT && y < GAME_Y_END) begin
            expect_eq("map_rd_y", map_rd_y, coord_t'(y - STATUS_HEIGHT));
        end
        expect_eq($sformatf("rgb at (%0d,%0d)", x, y), rgb, exp);
    endtask

    task automatic reset_and_blanking();
        expect_eq("rgb", rgb, 0);
        expect_eq("wr_ack", wr_ack, 0);
        in_display = 1'b1;
        probe(50, 40, COLOR_BG);
        probe(100, 40, COLOR_WALL);
        in_display = 1'b0;
        probe(100, 40, 12'h000);
        in_display = 1'b1;
    endtask

    task automatic tank_directions();
        host_write(ADDR_P1_POS, {1'b0, 8'd20, 8'd30});
        for (int d = 0; d < 4; d++) begin
            // alive, hp 3, no shield
            host_write(ADDR_P1_ATTR, reg_data_t'(6'b011100 | d));
            for (int r = 0; r < TANK_H; r++) begin
                for (int c = 0; c < TANK_W; c++) begin
                    probe(20 + c, STATUS_HEIGHT + 30 + r, sprite_on(d, c, r) ? COLOR_P1 : COLOR_BG);
                end
            end
        end
    endtask

    task automatic shield_priority();
        host_write(ADDR_P2_POS, {1'b0, 8'd101, 8'd60});
        host_write(ADDR_P2_ATTR, 17'h30);
        // ring sits on the wall column
        probe(100, 68, COLOR_SHIELD);
        probe(100, 67, COLOR_SHIELD);
        probe(104, 72, COLOR_SHIELD);
        probe(102, 68, COLOR_P2);
        probe(101, 68, COLOR_BG);
        host_write(ADDR_P2_ATTR, 17'h20);
        probe(100, 68, COLOR_WALL);
        probe(102, 68, COLOR_BG);
    endtask

    task automatic bullets_and_hearts();
        // one x band per bullet so squares never overlap
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            bx[i] = 30 + 15 * i + int'(rng % 10);
            by[i] = int'(rng[15:8] % 100);
            host_write(ADDR_BULLET_BASE + i, {1'b1, coord_t'(bx[i]), coord_t'(by[i])});
        end
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                probe(bx[i] + k % 2, STATUS_HEIGHT + by[i] + k / 2, COLOR_BULLET);
            end
        end
        host_write(ADDR_BULLET_BASE, {1'b0, coord_t'(bx[0]), coord_t'(by[0])});
        probe(bx[0], STATUS_HEIGHT + by[0], COLOR_BG);
        for (int h = 0; h < 4; h++) begin
            // p2 counts down so each bar follows its own hp
            host_write(ADDR_P1_ATTR, reg_data_t'(6'b010011 | (h << 2)));
            host_write(ADDR_P2_ATTR, reg_data_t'((3 - h) << 2));
            for (int k = 1; k <= 3; k++) begin
                probe(4 + 7 * (k - 1), 3, (h >= k) ? COLOR_HEART : COLOR_BG);
                probe(181 + 7 * (k - 1), 4, (3 - h >= k) ? COLOR_HEART : COLOR_BG);
            end
            probe(60, STATUS_HEIGHT - 1, COLOR_WALL);
        end
    endtask

    task automatic game_over_banner();
        host_write(ADDR_CTRL, 17'h3);
        probe(78, 70, COLOR_TEXT);
        probe(82, 70, COLOR_WIN_P1);
        probe(86, 70, COLOR_TEXT);
        probe(84, 70, COLOR_WIN_P1);
        probe(93, 76, COLOR_TEXT);
        probe(92, 76, COLOR_WIN_P1);
        // I glyph stem over the wall
        probe(100, 71, COLOR_TEXT);
        probe(104, 72, COLOR_TEXT);
        probe(70, 60, COLOR_WIN_P1);
        probe(129, 89, COLOR_WIN_P1);
        probe(130, 89, COLOR_BG);
        host_write(ADDR_CTRL, 17'h1);
        probe(85, 70, COLOR_TEXT);
        probe(88, 76, COLOR_TEXT);
        probe(84, 70, COLOR_WIN_P2);
        probe(129, 89, COLOR_WIN_P2);
    endtask

    initial begin
        in_reset_hint = 1'b1;
        wr_req        = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        pixel_x       = '0;
        pixel_y       = '0;
        in_display    = 1'b0;
        repeat (3) @(posedge pclk);
        @(negedge pclk);
        in_reset_hint = 1'b0;
        reset_and_blanking();
        tank_directions();
        shield_priority();
        bullets_and_hearts();
        game_over_banner();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verif/tb_tank_renderer_assert.sv ====
// handshake and blanking assertions, bound into every tank_renderer instance
`timescale 1ns/100ps

module handshake_blank_checks (
    input logic             pclk,
    input logic             in_reset_hint,
    input logic             wr_req,
    input logic             wr_ack,
    input logic             in_display,
    input render_pkg::rgb_t rgb
);

    ack_rise_needs_req: assert property (@(posedge pclk) disable iff (in_reset_hint)
        $rose(wr_ack) |-> $past(wr_req)) else $error("wr_ack rose without wr_req");

    ack_fall_needs_idle: assert property (@(posedge pclk) disable iff (in_reset_hint)
        $fell(wr_ack) |-> !$past(wr_req)) else $error("wr_ack fell while wr_req was high");

    // one register stage to the output
    blank_gives_black: assert property (@(posedge pclk) disable iff (in_reset_hint)
        !in_display |=> rgb == '0) else $error("rgb not blank after in_display low");

endmodule

bind tank_renderer handshake_blank_checks u_checks (
    .pclk, .in_reset_hint, .wr_req, .wr_ack, .in_display, .rgb
);

// ==== design/tank_renderer.sv ====
// renderer top: scene registers, sprite, bullet and banner logic feeding the rgb register
`timescale 1ns/100ps

module tank_renderer #(
    parameter int BULLET_NUM = 8
) (
    input  logic                  pclk,
    input  logic                  in_reset_hint,
    input  logic                  wr_req,
    input  render_pkg::reg_addr_t wr_addr,
    input  render_pkg::reg_data_t wr_data,
    output logic                  wr_ack,
    input  render_pkg::coord_t    pixel_x,
    input  render_pkg::row_t      pixel_y,
    input  logic                  in_display,
    output render_pkg::coord_t    map_rd_x,
    output render_pkg::coord_t    map_rd_y,
    input  logic                  map_wall,
    output render_pkg::rgb_t      rgb
);
    import render_pkg::*;

    coord_t                  p1_x, p1_y, p2_x, p2_y;
    dir_t                    p1_dir, p2_dir;
    hp_t                     p1_hp, p2_hp;
    logic                    p1_alive, p2_alive, p1_shield, p2_shield;
    logic [BULLET_NUM-1:0]   bullet_active;
    logic [BULLET_NUM*8-1:0] bullet_x, bullet_y;
    logic                    game_over, p1_win;
    row_t                    game_y;
    logic                    in_game;
    logic                    any_bullet, p1_body, p2_body, p1_shield_px, p2_shield_px;
    logic                    banner_box, banner_text;

    // play-field row, valid only while in_game
    assign game_y   = pixel_y - row_t'(STATUS_HEIGHT);
    assign in_game  = (pixel_y >= row_t'(STATUS_HEIGHT)) && (pixel_y < row_t'(GAME_Y_END));
    assign map_rd_x = pixel_x;
    assign map_rd_y = game_y[7:0];

    scene_regs #(.BULLET_NUM(BULLET_NUM)) u_regs (
        .pclk, .in_reset_hint, .wr_req, .wr_addr, .wr_data, .wr_ack,
        .p1_x, .p1_y, .p2_x, .p2_y, .p1_dir, .p2_dir, .p1_hp, .p2_hp,
        .p1_alive, .p2_alive, .p1_shield, .p2_shield,
        .bullet_active, .bullet_x, .bullet_y, .game_over, .p1_win
    );

    tank_sprite u_p1_sprite (
        .pixel_x, .game_y, .in_game, .tank_x(p1_x), .tank_y(p1_y), .tank_dir(p1_dir),
        .alive(p1_alive), .shield(p1_shield), .body_pixel(p1_body), .shield_pixel(p1_shield_px)
    );

    tank_sprite u_p2_sprite (
        .pixel_x, .game_y, .in_game, .tank_x(p2_x), .tank_y(p2_y), .tank_dir(p2_dir),
        .alive(p2_alive), .shield(p2_shield), .body_pixel(p2_body), .shield_pixel(p2_shield_px)
    );

    bullet_hit #(.BULLET_NUM(BULLET_NUM)) u_bullets (
        .pixel_x, .game_y, .in_game, .bullet_active, .bullet_x, .bullet_y, .any_bullet
    );

    win_banner u_banner (
        .pixel_x, .pixel_y, .game_over, .p1_win, .in_box(banner_box), .text_pixel(banner_text)
    );

    pixel_compose u_compose (
        .pclk, .in_reset_hint, .in_display, .pixel_x, .pixel_y, .in_game,
        .p1_hp, .p2_hp, .p1_win, .any_bullet, .p1_body, .p2_body,
        .p1_shield_px, .p2_shield_px, .map_wall, .banner_box, .banner_text, .rgb
    );

endmodule

// ==== design/pixel_compose.sv ====
// status bar, colour priority and the rgb output register of the renderer
`timescale 1ns/100ps

module pixel_compose (
    input  logic               pclk,
    input  logic               in_reset_hint,
    input  logic               in_display,
    input  render_pkg::coord_t pixel_x,
    input  render_pkg::row_t   pixel_y,
    input  logic               in_game,
    input  render_pkg::hp_t    p1_hp,
    input  render_pkg::hp_t    p2_hp,
    input  logic               p1_win,
    input  logic               any_bullet,
    input  logic               p1_body,
    input  logic               p2_body,
    input  logic               p1_shield_px,
    input  logic               p2_shield_px,
    input  logic               map_wall,
    input  logic               banner_box,
    input  logic               banner_text,
    output render_pkg::rgb_t   rgb
);
    import render_pkg::*;

    logic heart_row, p1_heart, p2_heart, status_line;

    // five pixels wide from left
    function automatic logic in_span(input coord_t x, input coord_t left);
        return ({1'b0, x} >= {1'b0, left}) && ({1'b0, x} < {1'b0, left} + 9'd5);
    endfunction

    assign heart_row = (pixel_y >= 9'd2) && (pixel_y <= 9'd5);
    assign p1_heart = (in_span(pixel_x, 8'd2) && p1_hp >= 2'd1) ||
                      (in_span(pixel_x, 8'd9) && p1_hp >= 2'd2) ||
                      (in_span(pixel_x, 8'd16) && p1_hp >= 2'd3);
    assign p2_heart = (in_span(pixel_x, 8'd179) && p2_hp >= 2'd1) ||
                      (in_span(pixel_x, 8'd186) && p2_hp >= 2'd2) ||
                      (in_span(pixel_x, 8'd193) && p2_hp >= 2'd3);
    assign status_line = (pixel_y == row_t'(STATUS_HEIGHT - 1));

    always_ff @(posedge pclk) begin
        if (in_reset_hint || !in_display) rgb <= '0;
        else if (banner_text) rgb <= COLOR_TEXT;
        else if (banner_box) rgb <= p1_win ? COLOR_WIN_P1 : COLOR_WIN_P2;
        else if (any_bullet) rgb <= COLOR_BULLET;
        else if (p1_shield_px || p2_shield_px) rgb <= COLOR_SHIELD;
        else if (p1_body) rgb <= COLOR_P1;
        else if (p2_body) rgb <= COLOR_P2;
        else if (in_game && map_wall) rgb <= COLOR_WALL;
        else if (heart_row && (p1_heart || p2_heart)) rgb <= COLOR_HEART;
        else if (status_line) rgb <= COLOR_WALL;
        else rgb <= COLOR_BG;
    end

endmodule

// ==== design/win_banner.sv ====
// game-over box and "P1 WIN" / "P2 WIN" text pixels from a six-glyph 5x7 ROM
`timescale 1ns/100ps

module win_banner (
    input  render_pkg::coord_t pixel_x,
    input  render_pkg::row_t   pixel_y,
    input  logic               game_over,
    input  logic               p1_win,
    output logic               in_box,
    output logic               text_pixel
);
    import render_pkg::*;

    // glyph rows packed top first, msb is the left column
    localparam logic [34:0] GLYPH [6] = '{
        35'b11110_10001_10001_11110_10000_10000_10000,  // P
        35'b00100_01100_00100_00100_00100_00100_01110,  // 1
        35'b01110_10001_00001_00110_01000_10000_11111,  // 2
        35'b10001_10001_10001_10101_10101_10101_01010,  // W
        35'b01110_00100_00100_00100_00100_00100_01110,  // I
        35'b10001_11001_10101_10101_10011_10001_10001   // N
    };
    localparam coord_t SLOT_X [5] = '{8'd78, 8'd84, 8'd92, 8'd98, 8'd104};

    logic [2:0] slot_code [5];
    logic [2:0] code;
    logic [2:0] col;
    logic [2:0] text_row;
    logic       in_slot;
    logic       in_text_rows;
    logic [4:0] line;

    assign slot_code[0] = 3'd0;
    assign slot_code[1] = p1_win ? 3'd1 : 3'd2;
    assign slot_code[2] = 3'd3;
    assign slot_code[3] = 3'd4;
    assign slot_code[4] = 3'd5;

    assign in_box = game_over && (pixel_x >= 8'd70) && (pixel_x <= 8'd129) &&
                    (pixel_y >= 9'd60) && (pixel_y <= 9'd89);
    assign in_text_rows = (pixel_y >= 9'd70) && (pixel_y <= 9'd76);
    assign text_row = 3'(pixel_y - 9'd70);

    // which character cell the pixel falls in
    always_comb begin
        in_slot = 1'b0;
        code    = 3'd0;
        col     = 3'd0;
        for (int s = 0; s < 5; s++) begin
            if (pixel_x >= SLOT_X[s] && pixel_x < SLOT_X[s] + 5) begin
                in_slot = 1'b1;
                code    = slot_code[s];
                col     = 3'(pixel_x - SLOT_X[s]);
            end
        end
    end

    assign line = GLYPH[code][34 - 5*text_row -: 5];
    assign text_pixel = game_over && in_text_rows && in_slot && line[3'd4 - col];

endmodule

// ==== design/bullet_hit.sv ====
// flags a pixel covered by any active bullet of the table
`timescale 1ns/100ps

module bullet_hit #(
    parameter int BULLET_NUM = 8
) (
    input  render_pkg::coord_t      pixel_x,
    input  render_pkg::row_t        game_y,
    input  logic                    in_game,
    input  logic [BULLET_NUM-1:0]   bullet_active,
    input  logic [BULLET_NUM*8-1:0] bullet_x,
    input  logic [BULLET_NUM*8-1:0] bullet_y,
    output logic                    any_bullet
);
    import render_pkg::*;

    logic [BULLET_NUM-1:0] hit;

    for (genvar i = 0; i < BULLET_NUM; i++) begin : g_bullet
        logic [8:0] dx, dy;
        // negative offsets wrap high and miss the square
        assign dx = {1'b0, pixel_x} - {1'b0, bullet_x[i*8 +: 8]};
        assign dy = game_y - {1'b0, bullet_y[i*8 +: 8]};
        assign hit[i] = bullet_active[i] && (dx < BULLET_SIZE) && (dy < BULLET_SIZE);
    end

    assign any_bullet = in_game && (|hit);

endmodule

// ==== design/tank_sprite.sv ====
// body and shield-ring pixels of one tank; one instance per player in the renderer top
`timescale 1ns/100ps

module tank_sprite (
    input  render_pkg::coord_t pixel_x,
    input  render_pkg::row_t   game_y,
    input  logic               in_game,
    input  render_pkg::coord_t tank_x,
    input  render_pkg::coord_t tank_y,
    input  render_pkg::dir_t   tank_dir,
    input  logic               alive,
    input  logic               shield,
    output logic               body_pixel,
    output logic               shield_pixel
);
    import render_pkg::*;

    // offsets with a one-pixel margin so the ring starts at 0
    logic [8:0] ox, oy;
    logic [8:0] col, row;
    logic       in_box, in_ring_box, shape;

    assign ox = {1'b0, pixel_x} + 9'd1 - {1'b0, tank_x};
    assign oy = game_y + 9'd1 - {1'b0, tank_y};
    assign col = ox - 9'd1;
    assign row = oy - 9'd1;

    assign in_box      = (col < TANK_W) && (row < TANK_H);
    assign in_ring_box = (ox < TANK_W + 2) && (oy < TANK_H + 2);

    always_comb begin
        case (tank_dir)
            DIR_UP:    shape = (row[1:0] != 2'd0) || (col[1:0] == 2'd1);
            DIR_DOWN:  shape = (row[1:0] != 2'd3) || (col[1:0] == 2'd1);
            DIR_LEFT:  shape = (col[1:0] == 2'd0) ? (row[1:0] == 2'd1) : (row[1:0] <= 2'd2);
            default:   shape = (col[1:0] == 2'd2) ? (row[1:0] == 2'd1) : (row[1:0] <= 2'd2);
        endcase
    end

    assign body_pixel   = alive && in_game && in_box && shape;
    assign shield_pixel = alive && shield && in_game && in_ring_box && !in_box;

endmodule

// ==== design/scene_regs.sv ====
// scene register block written by the host over a four-phase req/ack port; feeds the drawing logic
`timescale 1ns/100ps

module scene_regs #(
    parameter int BULLET_NUM = 8
) (
    input  logic                     pclk,
    input  logic                     in_reset_hint,
    input  logic                     wr_req,
    input  render_pkg::reg_addr_t    wr_addr,
    input  render_pkg::reg_data_t    wr_data,
    output logic                     wr_ack,
    output render_pkg::coord_t       p1_x,
    output render_pkg::coord_t       p1_y,
    output render_pkg::coord_t       p2_x,
    output render_pkg::coord_t       p2_y,
    output render_pkg::dir_t         p1_dir,
    output render_pkg::dir_t         p2_dir,
    output render_pkg::hp_t          p1_hp,
    output render_pkg::hp_t          p2_hp,
    output logic                     p1_alive,
    output logic                     p2_alive,
    output logic                     p1_shield,
    output logic                     p2_shield,
    output logic [BULLET_NUM-1:0]    bullet_active,
    output logic [BULLET_NUM*8-1:0]  bullet_x,
    output logic [BULLET_NUM*8-1:0]  bullet_y,
    output logic                     game_over,
    output logic                     p1_win
);
    import render_pkg::*;

    always_ff @(posedge pclk) begin
        if (in_reset_hint) begin
            wr_ack        <= 1'b0;
            {p1_x, p1_y, p2_x, p2_y} <= '0;
            {p1_dir, p1_hp, p1_alive, p1_shield} <= '0;
            {p2_dir, p2_hp, p2_alive, p2_shield} <= '0;
            bullet_active <= '0;
            bullet_x      <= '0;
            bullet_y      <= '0;
            game_over     <= 1'b0;
            p1_win        <= 1'b0;
        end else if (wr_req && !wr_ack) begin
            // take the write and ack in the same edge
            wr_ack <= 1'b1;
            case (wr_addr)
                ADDR_CTRL: begin
                    game_over <= wr_data[0];
                    p1_win    <= wr_data[1];
                end
                ADDR_P1_POS: {p1_x, p1_y} <= wr_data[15:0];
                ADDR_P1_ATTR: {p1_shield, p1_alive, p1_hp, p1_dir} <= wr_data[5:0];
                ADDR_P2_POS: {p2_x, p2_y} <= wr_data[15:0];
                ADDR_P2_ATTR: {p2_shield, p2_alive, p2_hp, p2_dir} <= wr_data[5:0];
                default: begin
                    // bullet table, anything else is dropped
                    for (int i = 0; i < BULLET_NUM; i++) begin
                        if (wr_addr == reg_addr_t'(ADDR_BULLET_BASE + i)) begin
                            bullet_active[i]   <= wr_data[16];
                            bullet_x[i*8 +: 8] <= wr_data[15:8];
                            bullet_y[i*8 +: 8] <= wr_data[7:0];
                        end
                    end
                end
            endcase
        end else if (!wr_req) begin
            wr_ack <= 1'b0;
        end
    end

endmodule

// ==== design/render_pkg.sv ====
// shared geometry, colours, register map and field types for the tank renderer; import where needed
package render_pkg;

    // screen geometry
    localparam int STATUS_HEIGHT = 8;
    localparam int GAME_Y_END    = 150;
    localparam int TANK_W        = 3;
    localparam int TANK_H        = 4;
    localparam int BULLET_SIZE   = 2;

    typedef logic [7:0]  coord_t;
    typedef logic [8:0]  row_t;
    typedef logic [1:0]  dir_t;
    typedef logic [1:0]  hp_t;
    typedef logic [11:0] rgb_t;

    // tank facing
    localparam dir_t DIR_UP    = 2'd0;
    localparam dir_t DIR_DOWN  = 2'd1;
    localparam dir_t DIR_LEFT  = 2'd2;
    localparam dir_t DIR_RIGHT = 2'd3;

    localparam rgb_t COLOR_BG     = 12'hFFF;
    localparam rgb_t COLOR_WALL   = 12'h333;
    localparam rgb_t COLOR_P1     = 12'h0A0;
    localparam rgb_t COLOR_P2     = 12'h00A;
    localparam rgb_t COLOR_BULLET = 12'hF80;
    localparam rgb_t COLOR_HEART  = 12'hF00;
    localparam rgb_t COLOR_SHIELD = 12'h0FF;
    localparam rgb_t COLOR_TEXT   = 12'h000;
    localparam rgb_t COLOR_WIN_P1 = 12'h0F0;
    localparam rgb_t COLOR_WIN_P2 = 12'h00F;

    // host write port
    typedef logic [5:0]  reg_addr_t;
    typedef logic [16:0] reg_data_t;

    localparam reg_addr_t ADDR_CTRL        = 6'd0;
    localparam reg_addr_t ADDR_P1_POS      = 6'd1;
    localparam reg_addr_t ADDR_P1_ATTR     = 6'd2;
    localparam reg_addr_t ADDR_P2_POS      = 6'd3;
    localparam reg_addr_t ADDR_P2_ATTR     = 6'd4;
    localparam reg_addr_t ADDR_BULLET_BASE = 6'd32;

endpackage
